// ==== dv/letc_core_e2w_asserts.sv ====
// Concurrent checks on the E2/W top level, attached to every letc_core_e2w instance by bind
`timescale 1ns/10ps
`default_nettype none

module letc_core_e2w_asserts (
    input wire logic                    i_clk,
    input wire logic                    i_rst_n,
    input wire logic                    i_stage_stall,
    input wire logic                    i_stage_flush,
    input wire logic                    i_rd_we,    // DUT o_rd_we
    input wire letc_core_pkg::reg_idx_t i_rd_idx,   // DUT o_rd_idx
    input wire letc_core_pkg::word_t    i_rd_wdata  // DUT o_rd_wdata
);

    // Hazard levels are exclusive
    a_stall_flush_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_stage_stall && i_stage_flush))
        else $error("stall and flush high in the same cycle");

    // Reset clears W valid, so no write right after it
    a_reset_no_write: assert property (@(posedge i_clk) !i_rst_n |=> !i_rd_we)
        else $error("register write in the cycle after reset");

    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rd_we |-> (i_rd_idx != '0))
        else $error("register write to x0");

    // W registers hold on a stalled edge
    a_stall_holds_w: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stage_stall |=> $stable(i_rd_we) && $stable(i_rd_idx) && $stable(i_rd_wdata))
        else $error("W outputs changed across a stall");

endmodule : letc_core_e2w_asserts

bind letc_core_e2w letc_core_e2w_asserts u_asserts (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_stage_stall(i_stage_stall),
    .i_stage_flush(i_stage_flush),
    .i_rd_we(o_rd_we),
    .i_rd_idx(o_rd_idx),
    .i_rd_wdata(o_rd_wdata)
);

`default_nettype wire

// ==== dv/letc_core_e2w_tb.sv ====
// Testbench for the E2/W back end: drives E1 instructions, models memory and W, checks writes
`timescale 1ns/10ps
`default_nettype none

module letc_core_e2w_tb;

    logic                    i_clk = 1'b0;
    logic                    i_rst_n;
    logic                    i_stage_stall;
    logic                    i_stage_flush;
    logic                    i_e1_valid;
    letc_core_pkg::mem_op_t  i_e1_mem_op;
    letc_core_pkg::rd_src_t  i_e1_rd_src;
    letc_core_pkg::reg_idx_t i_e1_rd_idx;
    logic                    i_e1_rd_we;
    letc_core_pkg::word_t    i_e1_alu_result;
    letc_core_pkg::word_t    i_e1_rs2_rdata;
    letc_core_pkg::word_t    i_e1_old_csr_value;
    logic                    o_rd_we;
    letc_core_pkg::reg_idx_t o_rd_idx;
    letc_core_pkg::word_t    o_rd_wdata;

    // Reference model: flat byte view of the four banks plus one W slot
    letc_core_pkg::byte_t    model_mem [0:4*letc_core_pkg::DMEM_WORDS-1];
    logic                    exp_rd_we = 1'b0;
    letc_core_pkg::reg_idx_t exp_rd_idx = '0;
    letc_core_pkg::word_t    exp_rd_wdata = '0;

    logic checking = 1'b0;   // Set once reset is released
    int   error_count = 0;
    int   check_count = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   errors_at_start = 0;

    letc_core_e2w DUT (.*);

    initial begin
        forever #10 i_clk = ~i_clk; // 20 ns period
    end

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    // Aligned and extended load as seen through the lanes
    function automatic letc_core_pkg::word_t load_from_model(input letc_core_pkg::mem_op_t op,
                                                             input letc_core_pkg::word_t addr);
        letc_core_pkg::byte_t b;
        logic [15:0]          h;
        letc_core_pkg::word_t w;
        b = model_mem[addr[9:0]];
        h = {model_mem[{addr[9:1], 1'b1}], model_mem[{addr[9:1], 1'b0}]}; // Bit 0 ignored
        w = {model_mem[{addr[9:2], 2'd3}], model_mem[{addr[9:2], 2'd2}],
             model_mem[{addr[9:2], 2'd1}], model_mem[{addr[9:2], 2'd0}]};
        case (op)
            letc_core_pkg::MEM_OP_LB:  return {{24{b[7]}}, b};
            letc_core_pkg::MEM_OP_LH:  return {{16{h[15]}}, h};
            letc_core_pkg::MEM_OP_LBU: return {24'd0, b};
            letc_core_pkg::MEM_OP_LHU: return {16'd0, h};
            default:                   return w; // LW, others see the raw word
        endcase
    endfunction

    // Expected register write value for one instruction
    function automatic letc_core_pkg::word_t expected_wdata(input letc_core_pkg::rd_src_t src,
                                                            input letc_core_pkg::mem_op_t op,
                                                            input letc_core_pkg::word_t alu,
                                                            input letc_core_pkg::word_t csr);
        case (src)
            letc_core_pkg::RD_SRC_MEM: return load_from_model(op, alu);
            letc_core_pkg::RD_SRC_CSR: return csr;
            default:                   return alu; // ALU and spare code
        endcase
    endfunction

    function automatic void apply_store(input letc_core_pkg::mem_op_t op,
                                        input letc_core_pkg::word_t addr,
                                        input letc_core_pkg::word_t data);
        case (op)
            letc_core_pkg::MEM_OP_SB: model_mem[addr[9:0]] = data[7:0];
            letc_core_pkg::MEM_OP_SH: begin
                model_mem[{addr[9:1], 1'b0}] = data[7:0];
                model_mem[{addr[9:1], 1'b1}] = data[15:8];
            end
            letc_core_pkg::MEM_OP_SW: begin
                for (int i = 0; i < 4; i++) begin
                    model_mem[{addr[9:2], i[1:0]}] = data[8*i +: 8];
                end
            end
            default: begin
            end
        endcase
    endfunction

    // Compare W, then advance the model by the same edge
    initial begin
        forever begin
            @(posedge i_clk);
            if (checking) begin
                compare_values("rd_we", {31'd0, o_rd_we}, {31'd0, exp_rd_we});
                if (exp_rd_we) begin
                    compare_values("rd_idx", {27'd0, o_rd_idx}, {27'd0, exp_rd_idx});
                    compare_values("rd_wdata", o_rd_wdata, exp_rd_wdata);
                end
            end
            if (!i_rst_n) begin
                exp_rd_we = 1'b0;
            end else if (!i_stage_stall) begin
                exp_rd_we    = i_e1_valid && i_e1_rd_we && (i_e1_rd_idx != 5'd0) && !i_stage_flush;
                exp_rd_idx   = i_e1_rd_idx;
                exp_rd_wdata = expected_wdata(i_e1_rd_src, i_e1_mem_op, i_e1_alu_result,
                                              i_e1_old_csr_value); // Before this edge's store
                if (i_e1_valid && !i_stage_flush) begin
                    apply_store(i_e1_mem_op, i_e1_alu_result, i_e1_rs2_rdata);
                end
            end
        end
    end

    task automatic drive_instr(input logic valid, input letc_core_pkg::mem_op_t op,
                               input letc_core_pkg::rd_src_t src,
                               input letc_core_pkg::reg_idx_t idx, input logic we,
                               input letc_core_pkg::word_t alu, input letc_core_pkg::word_t rs2,
                               input letc_core_pkg::word_t csr, input logic stall,
                               input logic flush);
        @(negedge i_clk);
        i_e1_valid         = valid;
        i_e1_mem_op        = op;
        i_e1_rd_src        = src;
        i_e1_rd_idx        = idx;
        i_e1_rd_we         = we;
        i_e1_alu_result    = alu;
        i_e1_rs2_rdata     = rs2;
        i_e1_old_csr_value = csr;
        i_stage_stall      = stall;
        i_stage_flush      = flush;
    endtask

    function automatic letc_core_pkg::reg_idx_t rand_dest();
        return letc_core_pkg::reg_idx_t'($urandom_range(31, 1)); // Never x0
    endfunction

    task automatic drive_bubble();
        drive_instr(1'b0, letc_core_pkg::MEM_OP_NOP, letc_core_pkg::RD_SRC_ALU, '0, 1'b0,
                    '0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic drive_store(input letc_core_pkg::mem_op_t op, input letc_core_pkg::word_t addr,
                               input letc_core_pkg::word_t data, input logic stall,
                               input logic flush);
        drive_instr(1'b1, op, letc_core_pkg::RD_SRC_ALU, '0, 1'b0, addr, data, '0, stall, flush);
    endtask

    task automatic drive_load(input letc_core_pkg::mem_op_t op, input letc_core_pkg::word_t addr);
        drive_instr(1'b1, op, letc_core_pkg::RD_SRC_MEM, rand_dest(), 1'b1, addr, $urandom,
                    $urandom, 1'b0, 1'b0);
    endtask

    task automatic load_all_widths(input letc_core_pkg::word_t addr);
        drive_load(letc_core_pkg::MEM_OP_LB, addr);
        drive_load(letc_core_pkg::MEM_OP_LBU, addr);
        drive_load(letc_core_pkg::MEM_OP_LH, addr);
        drive_load(letc_core_pkg::MEM_OP_LHU, addr);
        drive_load(letc_core_pkg::MEM_OP_LW, addr);
    endtask

    // Bubbles until a register write shows up, bounded
    task automatic await_rd_we(input int limit);
        int waited;
        waited = 0;
        do begin
            drive_bubble();
            waited++;
        end while (!o_rd_we && waited < limit);
        if (!o_rd_we) begin
            error_count++;
            $display("No register write appeared within %0d cycles of a writeback", limit);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = error_count - errors_at_start;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "bad", errs);
        errors_at_start = error_count;
    endtask

    task automatic reset_and_writeback();
        letc_core_pkg::rd_src_t  src;
        letc_core_pkg::reg_idx_t idx;
        compare_values("rd_we after reset", {31'd0, o_rd_we}, 32'd0);
        drive_instr(1'b1, letc_core_pkg::MEM_OP_NOP, letc_core_pkg::RD_SRC_ALU, rand_dest(),
                    1'b1, $urandom, '0, '0, 1'b0, 1'b0);
        await_rd_we(4);
        for (int n = 0; n < 40; n++) begin
            src = ($urandom_range(0, 1) == 0) ? letc_core_pkg::RD_SRC_ALU
                                               : letc_core_pkg::RD_SRC_CSR;
            idx = ($urandom_range(0, 5) == 0) ? 5'd0 : rand_dest(); // x0 now and then
            drive_instr(1'b1, letc_core_pkg::MEM_OP_NOP, src, idx, 1'b1, $urandom, $urandom,
                        $urandom, 1'b0, 1'b0);
        end
        drive_bubble();
        report_test("reset and ALU/CSR writeback");
    endtask

    // Every word gets a pattern built from its whole index
    task automatic fill_memory();
        letc_core_pkg::dmem_idx_t wi;
        for (int w = 0; w < letc_core_pkg::DMEM_WORDS; w++) begin
            wi = w[7:0];
            drive_store(letc_core_pkg::MEM_OP_SW, {22'd0, wi, 2'b00},
                        {~wi, wi ^ 8'hc3, wi + 8'h5b, wi}, 1'b0, 1'b0);
        end
    endtask

    task automatic word_roundtrip();
        letc_core_pkg::word_t addr;
        letc_core_pkg::word_t addrs [8];
        fill_memory();
        for (int n = 0; n < 20; n++) begin
            addr = $urandom;
            drive_store(letc_core_pkg::MEM_OP_SW, addr, $urandom, 1'b0, 1'b0);
            drive_load(letc_core_pkg::MEM_OP_LW, addr); // Right behind its store
        end
        for (int n = 0; n < 8; n++) begin
            addrs[n] = $urandom;
            drive_store(letc_core_pkg::MEM_OP_SW, addrs[n], $urandom, 1'b0, 1'b0);
        end
        for (int n = 0; n < 8; n++) begin
            drive_load(letc_core_pkg::MEM_OP_LW, addrs[n]);
        end
        drive_bubble();
        report_test("word store and load");
    endtask

    task automatic subword_access();
        letc_core_pkg::word_t base;
        letc_core_pkg::word_t addr;
        base = $urandom;
        for (int lane = 0; lane < 4; lane++) begin
            addr = {base[31:2], lane[1:0]};
            drive_store(letc_core_pkg::MEM_OP_SB, addr, $urandom, 1'b0, 1'b0);
            load_all_widths(addr);
            drive_store(letc_core_pkg::MEM_OP_SH, addr, $urandom, 1'b0, 1'b0);
            load_all_widths(addr);
        end
        drive_bubble();
        report_test("byte and half access");
    endtask

    task automatic stall_hold();
        letc_core_pkg::word_t addr;
        letc_core_pkg::word_t data;
        letc_core_pkg::word_t held;
        int                   len;
        for (int round = 0; round < 10; round++) begin
            addr = $urandom;
            data = $urandom;
            held = $urandom;   // ALU value parked in W across the stall
            len  = $urandom_range(2, 8);
            drive_instr(1'b1, letc_core_pkg::MEM_OP_NOP, letc_core_pkg::RD_SRC_ALU, rand_dest(),
                        1'b1, held, '0, '0, 1'b0, 1'b0);
            drive_store(letc_core_pkg::MEM_OP_SW, addr, data, 1'b1, 1'b0); // ALU write now in W
            for (int n = 1; n <= len; n++) begin
                // Last pass squashes the stalled store instead of releasing it
                drive_store(letc_core_pkg::MEM_OP_SW, addr, data, n < len, n == len);
                compare_values("rd_we held", {31'd0, o_rd_we}, 32'd1);
                compare_values("rd_wdata held", o_rd_wdata, held);
            end
            drive_load(letc_core_pkg::MEM_OP_LW, addr); // Still the old word
            data = $urandom;
            for (int n = 0; n < len; n++) begin
                drive_store(letc_core_pkg::MEM_OP_SW, addr, data, 1'b1, 1'b0);
            end
            drive_store(letc_core_pkg::MEM_OP_SW, addr, data, 1'b0, 1'b0); // Written here
            drive_load(letc_core_pkg::MEM_OP_LW, addr);
        end
        drive_bubble();
        report_test("stall hold");
    endtask

    task automatic flush_squash();
        letc_core_pkg::word_t addr;
        for (int round = 0; round < 10; round++) begin
            drive_instr(1'b1, letc_core_pkg::MEM_OP_NOP, letc_core_pkg::RD_SRC_CSR, rand_dest(),
                        1'b1, $urandom, '0, $urandom, 1'b0, 1'b1);
            drive_bubble();
            compare_values("rd_we after flush", {31'd0, o_rd_we}, 32'd0);
            addr = $urandom;
            drive_store(letc_core_pkg::MEM_OP_SW, addr, $urandom, 1'b0, 1'b1);
            drive_load(letc_core_pkg::MEM_OP_LW, addr); // Memory unchanged
        end
        drive_bubble();
        report_test("flush squash");
    endtask

    task automatic random_mix();
        int hazard;
        for (int n = 0; n < 500; n++) begin
            hazard = $urandom_range(0, 7); // 0 stalls, 1 flushes
            drive_instr($urandom_range(0, 7) != 0, letc_core_pkg::mem_op_t'($urandom_range(0, 8)),
                        letc_core_pkg::rd_src_t'($urandom_range(0, 3)),
                        letc_core_pkg::reg_idx_t'($urandom), $urandom_range(0, 1) == 1,
                        $urandom, $urandom, $urandom, hazard == 0, hazard == 1);
        end
        drive_bubble();
        drive_bubble();
        report_test("random mix");
    endtask

    initial begin
        int limit;
        limit = 10000;
        for (int cycles = 0; cycles < limit; cycles++) begin
            @(posedge i_clk);
        end
        $display("Simulation did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(92130));
        i_rst_n            = 1'b0;
        i_stage_stall      = 1'b0;
        i_stage_flush      = 1'b0;
        i_e1_valid         = 1'b0;
        i_e1_mem_op        = letc_core_pkg::MEM_OP_NOP;
        i_e1_rd_src        = letc_core_pkg::RD_SRC_ALU;
        i_e1_rd_idx        = '0;
        i_e1_rd_we         = 1'b0;
        i_e1_alu_result    = '0;
        i_e1_rs2_rdata     = '0;
        i_e1_old_csr_value = '0;
        repeat (2) @(negedge i_clk); // Two reset edges
        i_rst_n  = 1'b1;
        checking = 1'b1;
        reset_and_writeback();
        word_roundtrip();
        subword_access();
        stall_hold();
        flush_squash();
        random_mix();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : letc_core_e2w_tb

`default_nettype wire

// ==== letc_core_e2w.f ====
logic/letc_core_pkg.sv
logic/letc_core_stage_e2.sv
logic/letc_core_dmem_steer.sv
logic/letc_core_dmem_bank.sv
logic/letc_core_load_align.sv
logic/letc_core_stage_w.sv
logic/letc_core_e2w.sv
dv/letc_core_e2w_asserts.sv
dv/letc_core_e2w_tb.sv

// ==== logic/letc_core_dmem_bank.sv ====
// One byte-wide data memory bank with synchronous write and enabled registered read
`timescale 1ns/10ps
`default_nettype none

module letc_core_dmem_bank (
    input  wire logic                    i_clk,
    input  wire logic                    i_we,     // Write this lane
    input  wire logic                    i_rd_en,  // Update read register
    input  wire letc_core_pkg::dmem_idx_t i_idx,
    input  wire letc_core_pkg::byte_t     i_wbyte,
    output letc_core_pkg::byte_t          o_rbyte
);

    // Storage array, contents undefined after reset
    letc_core_pkg::byte_t mem [letc_core_pkg::DMEM_WORDS];

    // Write port
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_idx] <= i_wbyte;
        end
    end

    // Read port
    // Same-index write in this cycle returns the old byte
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rbyte <= mem[i_idx]; // Holds while stalled
        end
    end

endmodule : letc_core_dmem_bank

`default_nettype wire

// ==== logic/letc_core_dmem_steer.sv ====
// Store steering: turns one access into per-bank write enables, write bytes and a word index
`timescale 1ns/10ps
`default_nettype none

module letc_core_dmem_steer (
    input  wire logic                  i_store,   // Qualified store strobe from E2
    input  wire letc_core_pkg::mem_op_t i_mem_op,
    input  wire letc_core_pkg::word_t   i_addr,
    input  wire letc_core_pkg::word_t   i_wdata,

    output logic [letc_core_pkg::NUM_BANKS-1:0]                     o_bank_we,
    output letc_core_pkg::byte_t [letc_core_pkg::NUM_BANKS-1:0]     o_bank_wbyte,
    output letc_core_pkg::dmem_idx_t                                o_word_idx
);

    letc_core_pkg::byte_lane_t lane;

    assign lane       = i_addr[$bits(letc_core_pkg::byte_lane_t)-1:0];
    // Word index sits right above the lane bits, higher bits ignored
    assign o_word_idx = i_addr[$bits(letc_core_pkg::byte_lane_t) +: $bits(letc_core_pkg::dmem_idx_t)];

    always_comb begin
        o_bank_we    = '0;
        o_bank_wbyte = i_wdata; // Word layout by default

        case (i_mem_op)
            letc_core_pkg::MEM_OP_SB: begin
                for (int i = 0; i < letc_core_pkg::NUM_BANKS; i++) begin
                    o_bank_wbyte[i] = i_wdata[7:0]; // Low byte on every lane
                    o_bank_we[i]    = i_store && (lane == letc_core_pkg::byte_lane_t'(i));
                end
            end
            letc_core_pkg::MEM_OP_SH: begin
                // Low half on both halves, bit 1 picks the pair
                for (int i = 0; i < letc_core_pkg::NUM_BANKS; i++) begin
                    o_bank_wbyte[i] = i_wdata[8*(i%2) +: 8];
                    o_bank_we[i]    = i_store && (lane[1] == (i >= 2));
                end
            end
            letc_core_pkg::MEM_OP_SW: begin
                o_bank_we = {letc_core_pkg::NUM_BANKS{i_store}}; // All lanes
            end
            default: begin
                o_bank_we = '0; // Loads and NOP never write
            end
        endcase
    end

endmodule : letc_core_dmem_steer

`default_nettype wire

// ==== logic/letc_core_e2w.sv ====
// Back-end top level: E2, store steering, four memory banks, load alignment and W
`timescale 1ns/10ps
`default_nettype none

module letc_core_e2w (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire logic                   i_stage_stall,
    input  wire logic                   i_stage_flush,

    // E1 side
    input  wire logic                   i_e1_valid,
    input  wire letc_core_pkg::mem_op_t  i_e1_mem_op,
    input  wire letc_core_pkg::rd_src_t  i_e1_rd_src,
    input  wire letc_core_pkg::reg_idx_t i_e1_rd_idx,
    input  wire logic                   i_e1_rd_we,
    input  wire letc_core_pkg::word_t    i_e1_alu_result,
    input  wire letc_core_pkg::word_t    i_e1_rs2_rdata,
    input  wire letc_core_pkg::word_t    i_e1_old_csr_value,

    // Register write port
    output logic                        o_rd_we,
    output letc_core_pkg::reg_idx_t      o_rd_idx,
    output letc_core_pkg::word_t         o_rd_wdata
);

    // E2 to memory
    logic                     mem_store;
    logic                     mem_rd_en;
    letc_core_pkg::mem_op_t   mem_op;
    letc_core_pkg::word_t     mem_addr;
    letc_core_pkg::word_t     mem_wdata;

    // Steering to banks
    logic [letc_core_pkg::NUM_BANKS-1:0]                 bank_we;
    letc_core_pkg::byte_t [letc_core_pkg::NUM_BANKS-1:0] bank_wbyte;
    letc_core_pkg::byte_t [letc_core_pkg::NUM_BANKS-1:0] bank_rbyte;
    letc_core_pkg::dmem_idx_t                            word_idx;

    // E2 to W
    logic                     w_valid;
    letc_core_pkg::mem_op_t   w_mem_op;
    letc_core_pkg::byte_lane_t w_byte_lane;
    letc_core_pkg::rd_src_t   w_rd_src;
    letc_core_pkg::reg_idx_t  w_rd_idx;
    logic                     w_rd_we;
    letc_core_pkg::word_t     w_alu_result;
    letc_core_pkg::word_t     w_old_csr_value;
    letc_core_pkg::word_t     load_data;

    letc_core_stage_e2 u_stage_e2 (
        .i_clk, .i_rst_n, .i_stage_stall, .i_stage_flush,
        .i_e1_valid, .i_e1_mem_op, .i_e1_rd_src, .i_e1_rd_idx, .i_e1_rd_we,
        .i_e1_alu_result, .i_e1_rs2_rdata, .i_e1_old_csr_value,
        .o_mem_store(mem_store), .o_mem_rd_en(mem_rd_en), .o_mem_op(mem_op),
        .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata),
        .o_w_valid(w_valid), .o_w_mem_op(w_mem_op), .o_w_byte_lane(w_byte_lane),
        .o_w_rd_src(w_rd_src), .o_w_rd_idx(w_rd_idx), .o_w_rd_we(w_rd_we),
        .o_w_alu_result(w_alu_result), .o_w_old_csr_value(w_old_csr_value)
    );

    letc_core_dmem_steer u_steer (
        .i_store(mem_store), .i_mem_op(mem_op), .i_addr(mem_addr), .i_wdata(mem_wdata),
        .o_bank_we(bank_we), .o_bank_wbyte(bank_wbyte), .o_word_idx(word_idx)
    );

    // One bank per byte lane, all on the same word index
    for (genvar i = 0; i < letc_core_pkg::NUM_BANKS; i++) begin : g_bank
        letc_core_dmem_bank u_bank (
            .i_clk, .i_we(bank_we[i]), .i_rd_en(mem_rd_en), .i_idx(word_idx),
            .i_wbyte(bank_wbyte[i]), .o_rbyte(bank_rbyte[i])
        );
    end

    letc_core_load_align u_load_align (
        .i_bank_rbyte(bank_rbyte), .i_mem_op(w_mem_op), .i_byte_lane(w_byte_lane),
        .o_load_data(load_data)
    );

    letc_core_stage_w u_stage_w (
        .i_w_valid(w_valid), .i_w_rd_src(w_rd_src), .i_w_rd_idx(w_rd_idx),
        .i_w_rd_we(w_rd_we), .i_w_alu_result(w_alu_result),
        .i_w_old_csr_value(w_old_csr_value), .i_load_data(load_data),
        .o_rd_we, .o_rd_idx, .o_rd_wdata
    );

endmodule : letc_core_e2w

`default_nettype wire

// ==== logic/letc_core_load_align.sv ====
// Load alignment: picks the addressed byte or half from the bank lanes and extends it
`timescale 1ns/10ps
`default_nettype none

module letc_core_load_align (
    input  wire letc_core_pkg::byte_t [letc_core_pkg::NUM_BANKS-1:0] i_bank_rbyte,
    input  wire letc_core_pkg::mem_op_t    i_mem_op,    // Op registered in W
    input  wire letc_core_pkg::byte_lane_t i_byte_lane, // Address bits 1:0
    output letc_core_pkg::word_t           o_load_data
);

    letc_core_pkg::byte_t sel_byte; // Addressed byte
    logic [15:0]          sel_half; // Addressed half
    letc_core_pkg::word_t word;     // Lanes packed, lane 3 on top

    assign word     = i_bank_rbyte;
    assign sel_byte = i_bank_rbyte[i_byte_lane];

    // Bit 0 of the lane is ignored for halves
    assign sel_half = i_byte_lane[1] ? {i_bank_rbyte[3], i_bank_rbyte[2]}
                                     : {i_bank_rbyte[1], i_bank_rbyte[0]};

    always_comb begin
        case (i_mem_op)
            letc_core_pkg::MEM_OP_LB: begin
                o_load_data = {{24{sel_byte[7]}}, sel_byte}; // Sign extend
            end
            letc_core_pkg::MEM_OP_LH: begin
                o_load_data = {{16{sel_half[15]}}, sel_half};
            end
            letc_core_pkg::MEM_OP_LBU: begin
                o_load_data = {24'h000000, sel_byte}; // Zero extend
            end
            letc_core_pkg::MEM_OP_LHU: begin
                o_load_data = {16'h0000, sel_half};
            end
            default: begin
                // LW, and don't care for everything else
                o_load_data = word;
            end
        endcase
    end

endmodule : letc_core_load_align

`default_nettype wire

// ==== logic/letc_core_pkg.sv ====
// Shared widths, memory-op and writeback-source codes for the E2/W back end; use by scoped name
`default_nettype none

package letc_core_pkg;

    // Data memory geometry
    localparam int NUM_BANKS  = 4;   // One bank per byte lane
    localparam int DMEM_WORDS = 256; // Depth of each bank

    // Datapath words
    typedef logic [31:0] word_t;     // ALU result, store/load data, CSR value
    typedef logic [4:0]  reg_idx_t;  // Destination register index

    // Byte-banked memory types
    typedef logic [7:0]                      byte_t;      // One bank entry
    typedef logic [1:0]                      byte_lane_t; // Byte offset inside a word
    typedef logic [$clog2(DMEM_WORDS)-1:0]   dmem_idx_t;  // Word index inside a bank

    // Memory operation codes
    // Loads first, then stores, NOP is zero
    typedef logic [3:0] mem_op_t;

    localparam mem_op_t MEM_OP_NOP = 4'd0; // No memory access
    localparam mem_op_t MEM_OP_LB  = 4'd1; // Load byte, sign extended
    localparam mem_op_t MEM_OP_LH  = 4'd2; // Load half, sign extended
    localparam mem_op_t MEM_OP_LW  = 4'd3; // Load word
    localparam mem_op_t MEM_OP_LBU = 4'd4; // Load byte, zero extended
    localparam mem_op_t MEM_OP_LHU = 4'd5; // Load half, zero extended
    localparam mem_op_t MEM_OP_SB  = 4'd6; // Store byte
    localparam mem_op_t MEM_OP_SH  = 4'd7; // Store half
    localparam mem_op_t MEM_OP_SW  = 4'd8; // Store word

    // Writeback source select
    typedef logic [1:0] rd_src_t;

    localparam rd_src_t RD_SRC_ALU = 2'd0; // ALU result
    localparam rd_src_t RD_SRC_MEM = 2'd1; // Aligned load data
    localparam rd_src_t RD_SRC_CSR = 2'd2; // Old CSR value

    // Code 3 is unused and falls back to the ALU result in W

endpackage : letc_core_pkg

`default_nettype wire

// ==== logic/letc_core_stage_e2.sv ====
// Second execute stage: drives the data memory request and registers the instruction into W
`timescale 1ns/10ps
`default_nettype none

module letc_core_stage_e2 (
    // Clock and reset
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,

    // Hazard levels, never both high
    input  wire logic                   i_stage_stall,
    input  wire logic                   i_stage_flush,

    // From E1
    input  wire logic                   i_e1_valid,
    input  wire letc_core_pkg::mem_op_t  i_e1_mem_op,
    input  wire letc_core_pkg::rd_src_t  i_e1_rd_src,
    input  wire letc_core_pkg::reg_idx_t i_e1_rd_idx,
    input  wire logic                   i_e1_rd_we,
    input  wire letc_core_pkg::word_t    i_e1_alu_result,
    input  wire letc_core_pkg::word_t    i_e1_rs2_rdata,
    input  wire letc_core_pkg::word_t    i_e1_old_csr_value,

    // Data memory request
    output logic                        o_mem_store,
    output logic                        o_mem_rd_en,
    output letc_core_pkg::mem_op_t       o_mem_op,
    output letc_core_pkg::word_t         o_mem_addr,
    output letc_core_pkg::word_t         o_mem_wdata,

    // To W
    output logic                        o_w_valid,
    output letc_core_pkg::mem_op_t       o_w_mem_op,
    output letc_core_pkg::byte_lane_t    o_w_byte_lane,
    output letc_core_pkg::rd_src_t       o_w_rd_src,
    output letc_core_pkg::reg_idx_t      o_w_rd_idx,
    output logic                        o_w_rd_we,
    output letc_core_pkg::word_t         o_w_alu_result,
    output letc_core_pkg::word_t         o_w_old_csr_value
);

    logic is_store; // Any of SB, SH, SW

    assign is_store = (i_e1_mem_op == letc_core_pkg::MEM_OP_SB) ||
                      (i_e1_mem_op == letc_core_pkg::MEM_OP_SH) ||
                      (i_e1_mem_op == letc_core_pkg::MEM_OP_SW);

    // Memory answers in one cycle, so no busy path
    assign o_mem_store = i_e1_valid && is_store && !i_stage_flush && !i_stage_stall;
    assign o_mem_rd_en = !i_stage_stall;   // Bank read regs hold with the stage
    assign o_mem_op    = i_e1_mem_op;
    assign o_mem_addr  = i_e1_alu_result;  // ALU computed the address
    assign o_mem_wdata = i_e1_rs2_rdata;

    // Valid bit of the output flop stage
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_w_valid <= 1'b0;
        end else if (!i_stage_stall) begin
            if (i_stage_flush) begin
                o_w_valid <= 1'b0; // Squash next W
            end else begin
                o_w_valid <= i_e1_valid;
            end
        end
    end

    // Payload follows valid, held on stall
    always_ff @(posedge i_clk) begin
        if (!i_stage_stall) begin
            o_w_mem_op        <= i_e1_mem_op;
            o_w_byte_lane     <= i_e1_alu_result[$bits(letc_core_pkg::byte_lane_t)-1:0];
            o_w_rd_src        <= i_e1_rd_src;
            o_w_rd_idx        <= i_e1_rd_idx;
            o_w_rd_we         <= i_e1_rd_we;
            o_w_alu_result    <= i_e1_alu_result;
            o_w_old_csr_value <= i_e1_old_csr_value;
        end
    end

endmodule : letc_core_stage_e2

`default_nettype wire

// ==== logic/letc_core_stage_w.sv ====
// Writeback stage: selects the register write value and drives the register file write port
`timescale 1ns/10ps
`default_nettype none

module letc_core_stage_w (
    // From E2 output flops
    input  wire logic                   i_w_valid,
    input  wire letc_core_pkg::rd_src_t  i_w_rd_src,
    input  wire letc_core_pkg::reg_idx_t i_w_rd_idx,
    input  wire logic                   i_w_rd_we,
    input  wire letc_core_pkg::word_t    i_w_alu_result,
    input  wire letc_core_pkg::word_t    i_w_old_csr_value,

    // From load alignment
    input  wire letc_core_pkg::word_t    i_load_data,

    // Register file write port
    output logic                        o_rd_we,
    output letc_core_pkg::reg_idx_t      o_rd_idx,
    output letc_core_pkg::word_t         o_rd_wdata
);

    // x0 is hardwired, never written
    assign o_rd_we  = i_w_valid && i_w_rd_we && (i_w_rd_idx != '0);
    assign o_rd_idx = i_w_rd_idx;

    // Source mux
    always_comb begin
        case (i_w_rd_src)
            letc_core_pkg::RD_SRC_ALU: o_rd_wdata = i_w_alu_result;
            letc_core_pkg::RD_SRC_MEM: o_rd_wdata = i_load_data;
            letc_core_pkg::RD_SRC_CSR: o_rd_wdata = i_w_old_csr_value; // CSR read value
            default:                   o_rd_wdata = i_w_alu_result;    // Unused code
        endcase
    end

endmodule : letc_core_stage_w

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the E2/W testbench with Verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=letc_core_e2w_sim
LOG=sim.log

verilator --binary --timing --assert \
    -f letc_core_e2w.f \
    --top-module letc_core_e2w_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

exit 0
